// ==== flist.f ====
verilog/isa_pkg.sv
verilog/mem_pkg.sv
verilog/alu.sv
verilog/unified_mem.sv
verilog/mem_arbiter.sv
verilog/stage_fetch.sv
verilog/stage_execute.sv
verilog/stage_mem_wb.sv
verilog/cpu_top.sv
tests/tb_clock.sv
tests/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal
TOP       := tb_cpu
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(filter-out +%,$(shell cat $(FLIST)))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Some tests failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_cpu.sv ====
`timescale 1ns/100ps

module tb_cpu import isa_pkg::*, mem_pkg::*; ();

	localparam int DRIVE_DLY    = 10;
	localparam int RESET_CYCLES = 16;
	localparam int CPI_BOUND    = 10; // covers fetch and lw contention
	localparam int DBG_CYCLES   = 4;
	localparam int DATA_BASE    = 'h100;
	localparam int RES_BASE     = 'h110;
	localparam longint S32_MAX  = 64'sd2147483647;
	localparam longint S32_MIN  = -64'sd2147483648;

	logic                       clock;
	logic                       rst_n;
	logic                       run;
	logic                       dbg_valid;
	logic                       dbg_ready;
	logic                       dbg_we;
	logic [ADDR_W-1:0]          dbg_addr;
	logic [31:0]                dbg_wdata;
	logic                       dbg_rvalid;
	logic [31:0]                dbg_rdata;
	logic                       halted;
	logic [LED_SLOTS*LED_W-1:0] led_commands;

	logic [31:0] prog[$];
	logic [31:0] got[$];
	logic [31:0] expected[$];
	int          errors = 0;
	int          checks = 0;
	int          deadline = 64; // grows as each test starts
	int          cycle_count = 0;

	tb_clock u_clock (.o_clock(clock));

	cpu_top dut (
		.clock(clock), .i_rst_n(rst_n), .i_run(run),
		.i_dbg_valid(dbg_valid), .o_dbg_ready(dbg_ready), .i_dbg_we(dbg_we),
		.i_dbg_addr(dbg_addr), .i_dbg_wdata(dbg_wdata),
		.o_dbg_rvalid(dbg_rvalid), .o_dbg_rdata(dbg_rdata),
		.o_halted(halted), .o_led_commands(led_commands)
	);

	function automatic logic [31:0] enc_r(alu_op_e op, int rd, int rs, int rt, int sh);
		return {OP_RTYPE, rd[4:0], rs[4:0], rt[4:0], sh[4:0], op, 2'b00};
	endfunction

	function automatic logic [31:0] enc_i(opcode_e op, int rd, int rs, int imm);
		return {op, rd[4:0], rs[4:0], imm[16:0]};
	endfunction

	function automatic logic [31:0] enc_j(opcode_e op, int target);
		return {op, target[26:0]};
	endfunction

	function automatic logic [31:0] enc_led(int rs, int rt);
		return {OP_LED, 5'd0, rs[4:0], rt[4:0], 12'd0};
	endfunction

	task automatic reset_dut();
		deadline += RESET_CYCLES + 4;
		rst_n     = 1'b0;
		run       = 1'b0;
		dbg_valid = 1'b0;
		dbg_we    = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#DRIVE_DLY;
		rst_n = 1'b1;
	endtask

	task automatic wait_dbg_accept();
		logic acc;
		acc = 1'b0;
		while (!acc) begin
			@(negedge clock);
			acc = dbg_ready;
			@(posedge clock);
			#DRIVE_DLY;
		end
	endtask

	task automatic dbg_write(input int addr, input logic [31:0] data);
		dbg_valid = 1'b1;
		dbg_we    = 1'b1;
		dbg_addr  = addr[ADDR_W-1:0];
		dbg_wdata = data;
		wait_dbg_accept();
		dbg_valid = 1'b0;
		dbg_we    = 1'b0;
	endtask

	task automatic dbg_read(input int addr, output logic [31:0] data);
		logic seen;
		dbg_valid = 1'b1;
		dbg_we    = 1'b0;
		dbg_addr  = addr[ADDR_W-1:0];
		wait_dbg_accept();
		dbg_valid = 1'b0;
		seen      = 1'b0;
		while (!seen) begin
			@(negedge clock);
			seen = dbg_rvalid;
			data = dbg_rdata;
			@(posedge clock);
			#DRIVE_DLY;
		end
	endtask

	// load prog at word 0, run to halt, read n_res words from res_base
	task automatic run_program(input int exec_insns, input int res_base, input int n_res);
		int          limit;
		int          n;
		logic        done;
		logic [31:0] w;
		limit     = exec_insns * CPI_BOUND;
		deadline += (prog.size() + 2 * n_res) * DBG_CYCLES + limit + 32;
		run = 1'b0;
		for (int i = 0; i < prog.size(); i++)
			dbg_write(i, prog[i]);
		for (int i = 0; i < n_res; i++)
			dbg_write(res_base + i, 32'd0);
		run  = 1'b1;
		n    = 0;
		done = 1'b0;
		while (!done && n < limit) begin
			@(negedge clock);
			done = halted;
			@(posedge clock);
			#DRIVE_DLY;
			n++;
		end
		run = 1'b0;
		if (!done) begin
			errors++;
			$display("program did not reach halt within %0d cycles", limit);
		end
		got.delete();
		for (int i = 0; i < n_res; i++) begin
			dbg_read(res_base + i, w);
			got.push_back(w);
		end
	endtask

	task automatic check_word(input string what, input logic [31:0] actual,
		input logic [31:0] exp);
		checks++;
		if (actual !== exp) begin
			errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, actual, exp);
		end
	endtask

	task automatic check_leds(input string what, input logic [LED_SLOTS*LED_W-1:0] actual,
		input logic [LED_SLOTS*LED_W-1:0] exp);
		checks++;
		if (actual !== exp) begin
			errors++;
			$display("FAIL %0t: %s got %h expected %h", $time, what, actual, exp);
		end
	endtask

	task automatic check_results(input string name);
		for (int i = 0; i < expected.size(); i++)
			check_word($sformatf("%s word %0d", name, i), got[i], expected[i]);
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - errs_before);
	endtask

	task automatic test_alu();
		int          e0;
		logic [31:0] a;
		logic [31:0] b;
		int          sh1;
		int          sh2;
		longint      s;
		logic        add_ovf;
		logic        sub_ovf;
		e0 = errors;
		for (int round = 0; round < 4; round++) begin
			a   = $urandom;
			b   = $urandom;
			sh1 = $urandom_range(31, 0);
			sh2 = $urandom_range(31, 0);
			reset_dut();
			dbg_write(DATA_BASE, a);
			dbg_write(DATA_BASE + 1, b);
			prog.delete();
			prog.push_back(enc_i(OP_LW, 1, 0, DATA_BASE));
			prog.push_back(enc_i(OP_LW, 2, 0, DATA_BASE + 1));
			prog.push_back(enc_r(ALU_ADD, 3, 1, 2, 0));
			prog.push_back(enc_r(ALU_SUB, 4, 1, 2, 0));
			prog.push_back(enc_r(ALU_AND, 5, 1, 2, 0));
			prog.push_back(enc_r(ALU_OR, 6, 1, 2, 0));
			prog.push_back(enc_r(ALU_SLL, 7, 1, 0, sh1));
			prog.push_back(enc_r(ALU_SRA, 8, 2, 0, sh2));
			for (int r = 3; r <= 8; r++)
				prog.push_back(enc_i(OP_SW, r, 0, RES_BASE + r - 3));
			prog.push_back(enc_i(OP_SW, 30, 0, RES_BASE + 6));
			prog.push_back(enc_j(OP_HALT, 0));
			run_program(prog.size(), RES_BASE, 7);
			s       = longint'($signed(a)) + longint'($signed(b));
			add_ovf = (s > S32_MAX) || (s < S32_MIN);
			s       = longint'($signed(a)) - longint'($signed(b));
			sub_ovf = (s > S32_MAX) || (s < S32_MIN);
			expected.delete();
			expected.push_back(add_ovf ? 32'd0 : a + b); // rd untouched on overflow
			expected.push_back(sub_ovf ? 32'd0 : a - b);
			expected.push_back(a & b);
			expected.push_back(a | b);
			expected.push_back(a << sh1);
			expected.push_back($signed(b) >>> sh2);
			expected.push_back(sub_ovf ? 32'd3 : add_ovf ? 32'd1 : 32'd0);
			check_results($sformatf("alu round %0d", round));
		end
		report_test("alu_arith", e0);
	endtask

	task automatic test_forwarding();
		int e0;
		int a;
		int b;
		int c;
		int d;
		int e;
		e0 = errors;
		reset_dut();
		prog.delete();
		prog.push_back(enc_i(OP_ADDI, 1, 0, 5));
		prog.push_back(enc_i(OP_ADDI, 2, 1, 7));
		prog.push_back(enc_r(ALU_ADD, 3, 2, 1, 0));
		prog.push_back(enc_r(ALU_SUB, 4, 3, 2, 0));
		prog.push_back(enc_r(ALU_SLL, 5, 4, 0, 3));
		prog.push_back(enc_i(OP_SW, 5, 0, DATA_BASE));
		prog.push_back(enc_i(OP_LW, 6, 0, DATA_BASE));
		prog.push_back(enc_i(OP_ADDI, 7, 6, 1)); // load-use
		prog.push_back(enc_r(ALU_ADD, 8, 7, 6, 0));
		prog.push_back(enc_i(OP_LW, 9, 0, DATA_BASE));
		prog.push_back(enc_i(OP_SW, 9, 0, DATA_BASE + 1));
		prog.push_back(enc_i(OP_LW, 11, 0, DATA_BASE + 1));
		prog.push_back(enc_i(OP_SW, 3, 0, RES_BASE));
		prog.push_back(enc_i(OP_SW, 4, 0, RES_BASE + 1));
		prog.push_back(enc_i(OP_SW, 7, 0, RES_BASE + 2));
		prog.push_back(enc_i(OP_SW, 8, 0, RES_BASE + 3));
		prog.push_back(enc_i(OP_SW, 11, 0, RES_BASE + 4));
		prog.push_back(enc_j(OP_HALT, 0));
		run_program(prog.size(), RES_BASE, 5);
		a = 5;
		b = a + 7;
		c = b + a;
		d = c - b;
		e = d << 3;
		expected.delete();
		expected.push_back(c);
		expected.push_back(d);
		expected.push_back(e + 1);
		expected.push_back(e + 1 + e);
		expected.push_back(e);
		check_results("forwarding");
		report_test("forwarding", e0);
	endtask

	task automatic test_control();
		int e0;
		e0 = errors;
		reset_dut();
		prog.delete();
		prog.push_back(enc_i(OP_ADDI, 1, 0, 3));
		prog.push_back(enc_i(OP_ADDI, 2, 0, 3));
		prog.push_back(enc_i(OP_BNE, 1, 2, 1)); // equal, falls through
		prog.push_back(enc_i(OP_ADDI, 10, 0, 1));
		prog.push_back(enc_i(OP_ADDI, 2, 0, 9));
		prog.push_back(enc_i(OP_BNE, 1, 2, 1)); // to 7
		prog.push_back(enc_i(OP_ADDI, 11, 0, 'h55));
		prog.push_back(enc_i(OP_BLT, 1, 2, 1)); // 3 < 9, to 9
		prog.push_back(enc_i(OP_ADDI, 12, 0, 'h66));
		prog.push_back(enc_i(OP_BLT, 2, 1, 1)); // 9 < 3 is false
		prog.push_back(enc_i(OP_ADDI, 13, 0, 2));
		prog.push_back(enc_j(OP_JAL, 15)); // pc 11
		prog.push_back(enc_j(OP_J, 17));
		prog.push_back(enc_i(OP_ADDI, 15, 0, 'h88));
		prog.push_back(enc_i(OP_ADDI, 15, 0, 'h99));
		prog.push_back(enc_i(OP_ADDI, 16, 0, 4));
		prog.push_back(enc_i(OP_JR, 31, 0, 0));
		prog.push_back(enc_i(OP_SW, 10, 0, RES_BASE));
		prog.push_back(enc_i(OP_SW, 11, 0, RES_BASE + 1));
		prog.push_back(enc_i(OP_SW, 12, 0, RES_BASE + 2));
		prog.push_back(enc_i(OP_SW, 13, 0, RES_BASE + 3));
		prog.push_back(enc_i(OP_SW, 15, 0, RES_BASE + 4));
		prog.push_back(enc_i(OP_SW, 16, 0, RES_BASE + 5));
		prog.push_back(enc_i(OP_SW, 31, 0, RES_BASE + 6));
		prog.push_back(enc_j(OP_HALT, 0));
		run_program(prog.size(), RES_BASE, 7);
		expected = '{32'd1, 32'd0, 32'd0, 32'd2, 32'd0, 32'd4, 32'd12};
		check_results("control");
		report_test("control_flow", e0);
	endtask

	task automatic test_exceptions();
		int e0;
		e0 = errors;
		reset_dut();
		prog.delete();
		prog.push_back(enc_i(OP_ADDI, 1, 0, 1));
		prog.push_back(enc_r(ALU_SLL, 4, 1, 0, 30));
		prog.push_back(enc_i(OP_ADDI, 3, 4, -1));
		prog.push_back(enc_r(ALU_ADD, 2, 3, 4, 0)); // largest positive word
		prog.push_back(enc_r(ALU_ADD, 5, 2, 1, 0));
		prog.push_back(enc_i(OP_SW, 30, 0, RES_BASE));
		prog.push_back(enc_i(OP_SW, 5, 0, RES_BASE + 1));
		prog.push_back(enc_i(OP_ADDI, 6, 2, 1));
		prog.push_back(enc_i(OP_SW, 30, 0, RES_BASE + 2));
		prog.push_back(enc_r(ALU_SLL, 7, 1, 0, 31));
		prog.push_back(enc_r(ALU_SUB, 8, 7, 1, 0));
		prog.push_back(enc_i(OP_SW, 30, 0, RES_BASE + 3));
		prog.push_back(enc_j(OP_SETX, 0));
		prog.push_back(enc_j(OP_BEX, 15)); // r30 is zero
		prog.push_back(enc_i(OP_ADDI, 9, 0, 1));
		prog.push_back(enc_j(OP_SETX, 5));
		prog.push_back(enc_j(OP_BEX, 18));
		prog.push_back(enc_i(OP_ADDI, 10, 0, 1));
		prog.push_back(enc_i(OP_SW, 9, 0, RES_BASE + 4));
		prog.push_back(enc_i(OP_SW, 10, 0, RES_BASE + 5));
		prog.push_back(enc_i(OP_SW, 30, 0, RES_BASE + 6));
		prog.push_back(enc_j(OP_HALT, 0));
		run_program(prog.size(), RES_BASE, 7);
		expected = '{EXC_ADD, 32'd0, EXC_ADDI, EXC_SUB, 32'd1, 32'd0, 32'd5};
		check_results("exceptions");
		report_test("exceptions", e0);
	endtask

	task automatic test_leds();
		int                         e0;
		logic [LED_SLOTS*LED_W-1:0] exp_leds;
		e0 = errors;
		reset_dut();
		prog.delete();
		prog.push_back(enc_i(OP_ADDI, 1, 0, 'h1234));
		prog.push_back(enc_i(OP_ADDI, 2, 0, 'habcd));
		prog.push_back(enc_i(OP_ADDI, 3, 0, 'h0f0f));
		prog.push_back(enc_i(OP_ADDI, 4, 0, 4));
		prog.push_back(enc_i(OP_ADDI, 5, 0, 8));
		prog.push_back(enc_i(OP_ADDI, 6, 0, 12));
		prog.push_back(enc_led(1, 0));
		prog.push_back(enc_led(2, 4));
		prog.push_back(enc_led(3, 5));
		prog.push_back(enc_led(1, 6)); // slot 12 does not exist
		prog.push_back(enc_j(OP_HALT, 0));
		run_program(prog.size(), RES_BASE, 0);
		exp_leds = '0;
		exp_leds[0*LED_W +: LED_W] = 16'h1234;
		exp_leds[4*LED_W +: LED_W] = 16'habcd;
		exp_leds[8*LED_W +: LED_W] = 16'h0f0f;
		check_leds("led bank", led_commands, exp_leds);
		report_test("led_bank", e0);
	endtask

	task automatic test_arbitration();
		int e0;
		int sum;
		e0 = errors;
		reset_dut();
		prog.delete();
		prog.push_back(enc_i(OP_ADDI, 1, 0, 0));
		prog.push_back(enc_i(OP_ADDI, 2, 0, 8));
		prog.push_back(enc_i(OP_ADDI, 3, 0, 'h2a));
		prog.push_back(enc_r(ALU_ADD, 4, 3, 1, 0)); // loop head, pc 3
		prog.push_back(enc_r(ALU_SLL, 4, 4, 0, 2));
		prog.push_back(enc_i(OP_SW, 4, 1, RES_BASE + 16));
		prog.push_back(enc_i(OP_LW, 5, 1, RES_BASE + 16));
		prog.push_back(enc_r(ALU_ADD, 6, 6, 5, 0));
		prog.push_back(enc_i(OP_ADDI, 1, 1, 1));
		prog.push_back(enc_i(OP_BLT, 1, 2, -7));
		prog.push_back(enc_i(OP_SW, 6, 0, RES_BASE));
		prog.push_back(enc_j(OP_HALT, 0));
		run_program(3 + 8 * 7 + 2, RES_BASE, 24);
		sum = 0;
		for (int i = 0; i < 8; i++)
			sum += (('h2a + i) << 2);
		expected.delete();
		expected.push_back(sum);
		repeat (15) expected.push_back(32'd0); // no stray writes
		for (int i = 0; i < 8; i++)
			expected.push_back(('h2a + i) << 2);
		check_results("arbitration");
		report_test("arbitration", e0);
	endtask

	initial begin
		while (cycle_count <= deadline) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: the run went past its budget of %0d clock cycles", deadline);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		rst_n     = 1'b0;
		run       = 1'b0;
		dbg_valid = 1'b0;
		dbg_we    = 1'b0;
		dbg_addr  = '0;
		dbg_wdata = 32'd0;
		void'($urandom(54));
		test_alu();
		test_forwarding();
		test_control();
		test_exceptions();
		test_leds();
		test_arbitration();
		$display("tests: 6, checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic o_clock
);

	initial o_clock = 1'b0;

	always #(PERIOD / 2) o_clock = !o_clock;

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/100ps

module cpu_top import isa_pkg::*, mem_pkg::*; (
	input  logic                       clock,
	input  logic                       i_rst_n,
	input  logic                       i_run,
	input  logic                       i_dbg_valid,
	output logic                       o_dbg_ready,
	input  logic                       i_dbg_we,
	input  logic [ADDR_W-1:0]          i_dbg_addr,
	input  logic [31:0]                i_dbg_wdata,
	output logic                       o_dbg_rvalid,
	output logic [31:0]                o_dbg_rdata,
	output logic                       o_halted,
	output logic [LED_SLOTS*LED_W-1:0] o_led_commands
);

	logic              freq_valid;
	logic              freq_ready;
	logic [ADDR_W-1:0] freq_addr;
	logic              fresp_valid;
	logic              insn_valid;
	logic              x_ready;
	logic [31:0]       insn;
	logic [31:0]       insn_pc;
	logic              redirect;
	logic [31:0]       redirect_pc;
	logic [4:0]        rs_addr;
	logic [4:0]        rt_addr;
	logic [31:0]       rs_data;
	logic [31:0]       rt_data;
	logic              wb_valid;
	logic              wb_ready;
	opcode_e           wb_kind;
	logic [4:0]        wb_rd;
	logic [31:0]       wb_result;
	logic [31:0]       wb_store;
	logic              dreq_valid;
	logic              dreq_ready;
	logic              dreq_we;
	logic [ADDR_W-1:0] dreq_addr;
	logic [31:0]       dreq_wdata;
	logic              dresp_valid;
	logic              mem_en;
	logic              mem_we;
	logic [ADDR_W-1:0] mem_addr;
	logic [31:0]       mem_wdata;
	logic [31:0]       mem_rdata;

	// read data is shared by all requesters, rvalid tells whose it is
	stage_fetch u_fetch (
		.clock(clock), .i_rst_n(i_rst_n), .i_run(i_run),
		.o_req_valid(freq_valid), .i_req_ready(freq_ready), .o_req_addr(freq_addr),
		.i_resp_valid(fresp_valid), .i_resp_data(o_dbg_rdata),
		.o_insn_valid(insn_valid), .i_x_ready(x_ready),
		.o_insn(insn), .o_insn_pc(insn_pc),
		.i_redirect(redirect), .i_redirect_pc(redirect_pc)
	);

	stage_execute u_execute (
		.clock(clock), .i_rst_n(i_rst_n),
		.i_insn_valid(insn_valid), .o_x_ready(x_ready), .i_insn(insn), .i_insn_pc(insn_pc),
		.o_rs_addr(rs_addr), .o_rt_addr(rt_addr), .i_rs_data(rs_data), .i_rt_data(rt_data),
		.o_wb_valid(wb_valid), .i_wb_ready(wb_ready), .o_wb_kind(wb_kind), .o_wb_rd(wb_rd),
		.o_wb_result(wb_result), .o_wb_store(wb_store),
		.o_redirect(redirect), .o_redirect_pc(redirect_pc),
		.o_halted(o_halted), .o_led_commands(o_led_commands)
	);

	stage_mem_wb u_mem_wb (
		.clock(clock), .i_rst_n(i_rst_n),
		.i_wb_valid(wb_valid), .o_ready(wb_ready), .i_wb_kind(wb_kind), .i_wb_rd(wb_rd),
		.i_wb_result(wb_result), .i_wb_store(wb_store),
		.i_rs_addr(rs_addr), .i_rt_addr(rt_addr), .o_rs_data(rs_data), .o_rt_data(rt_data),
		.o_dreq_valid(dreq_valid), .i_dreq_ready(dreq_ready), .o_dreq_we(dreq_we),
		.o_dreq_addr(dreq_addr), .o_dreq_wdata(dreq_wdata),
		.i_dresp_valid(dresp_valid), .i_dresp_data(o_dbg_rdata)
	);

	mem_arbiter u_arbiter (
		.clock(clock), .i_rst_n(i_rst_n),
		.i_dbg_valid(i_dbg_valid), .o_dbg_ready(o_dbg_ready), .i_dbg_we(i_dbg_we),
		.i_dbg_addr(i_dbg_addr), .i_dbg_wdata(i_dbg_wdata),
		.i_data_valid(dreq_valid), .o_data_ready(dreq_ready), .i_data_we(dreq_we),
		.i_data_addr(dreq_addr), .i_data_wdata(dreq_wdata),
		.i_fetch_valid(freq_valid), .o_fetch_ready(freq_ready), .i_fetch_we(1'b0),
		.i_fetch_addr(freq_addr), .i_fetch_wdata(32'd0),
		.o_mem_en(mem_en), .o_mem_we(mem_we), .o_mem_addr(mem_addr),
		.o_mem_wdata(mem_wdata), .i_mem_rdata(mem_rdata),
		.o_dbg_rvalid(o_dbg_rvalid), .o_data_rvalid(dresp_valid),
		.o_fetch_rvalid(fresp_valid), .o_rdata(o_dbg_rdata)
	);

	unified_mem u_mem (
		.clock(clock), .i_en(mem_en), .i_we(mem_we),
		.i_addr(mem_addr), .i_wdata(mem_wdata), .o_rdata(mem_rdata)
	);

endmodule

// ==== verilog/stage_mem_wb.sv ====
`timescale 1ns/100ps

module stage_mem_wb import isa_pkg::*, mem_pkg::*; (
	input  logic              clock,
	input  logic              i_rst_n,
	input  logic              i_wb_valid,
	output logic              o_ready,
	input  opcode_e           i_wb_kind,
	input  logic [4:0]        i_wb_rd,
	input  logic [31:0]       i_wb_result,
	input  logic [31:0]       i_wb_store,
	input  logic [4:0]        i_rs_addr,
	input  logic [4:0]        i_rt_addr,
	output logic [31:0]       o_rs_data,
	output logic [31:0]       o_rt_data,
	output logic              o_dreq_valid,
	input  logic              i_dreq_ready,
	output logic              o_dreq_we,
	output logic [ADDR_W-1:0] o_dreq_addr,
	output logic [31:0]       o_dreq_wdata,
	input  logic              i_dresp_valid,
	input  logic [31:0]       i_dresp_data
);

	logic        v_q;
	logic        ld_wait_q;
	opcode_e     kind_q;
	logic [4:0]  rd_q;
	logic [31:0] res_q;
	logic [31:0] store_q;
	logic [31:0] rf [32];
	logic        is_ld;
	logic        is_st;
	logic        writes;
	logic        done;
	logic        wr_en;
	logic [31:0] wr_data;

	assign is_ld  = (kind_q == OP_LW);
	assign is_st  = (kind_q == OP_SW);
	assign writes = (kind_q == OP_RTYPE) || (kind_q == OP_ADDI) || (kind_q == OP_JAL) ||
		(kind_q == OP_SETX) || is_ld;

	assign o_dreq_valid = v_q && (is_st || (is_ld && !ld_wait_q));
	assign o_dreq_we    = is_st;
	assign o_dreq_addr  = res_q[ADDR_W-1:0];
	assign o_dreq_wdata = store_q;

	assign done    = v_q && (is_ld ? (ld_wait_q && i_dresp_valid) : is_st ? i_dreq_ready : 1'b1);
	assign o_ready = !v_q || done;
	assign wr_en   = done && writes && (rd_q != 5'd0);
	assign wr_data = is_ld ? i_dresp_data : res_q;

	// result about to retire beats the register file
	assign o_rs_data = (wr_en && (rd_q == i_rs_addr)) ? wr_data : rf[i_rs_addr];
	assign o_rt_data = (wr_en && (rd_q == i_rt_addr)) ? wr_data : rf[i_rt_addr];

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			v_q       <= 1'b0;
			ld_wait_q <= 1'b0;
			for (int i = 0; i < 32; i++)
				rf[i] <= 32'd0;
		end else begin
			if (o_ready)
				v_q <= i_wb_valid;
			if (o_dreq_valid && i_dreq_ready && !o_dreq_we)
				ld_wait_q <= 1'b1;
			else if (i_dresp_valid)
				ld_wait_q <= 1'b0;
			if (wr_en)
				rf[rd_q] <= wr_data;
		end
	end

	always_ff @(posedge clock) begin
		if (i_wb_valid && o_ready) begin
			kind_q  <= i_wb_kind;
			rd_q    <= i_wb_rd;
			res_q   <= i_wb_result; // address for lw and sw
			store_q <= i_wb_store;
		end
	end

	// load data only comes back to a waiting lw
	assert property (@(posedge clock) disable iff (!i_rst_n)
		i_dresp_valid |-> v_q && is_ld && ld_wait_q);

endmodule

// ==== verilog/stage_execute.sv ====
`timescale 1ns/100ps

module stage_execute import isa_pkg::*; (
	input  logic                       clock,
	input  logic                       i_rst_n,
	input  logic                       i_insn_valid,
	output logic                       o_x_ready,
	input  logic [31:0]                i_insn,
	input  logic [31:0]                i_insn_pc,
	output logic [4:0]                 o_rs_addr,
	output logic [4:0]                 o_rt_addr,
	input  logic [31:0]                i_rs_data,
	input  logic [31:0]                i_rt_data,
	output logic                       o_wb_valid,
	input  logic                       i_wb_ready,
	output opcode_e                    o_wb_kind,
	output logic [4:0]                 o_wb_rd,
	output logic [31:0]                o_wb_result,
	output logic [31:0]                o_wb_store,
	output logic                       o_redirect,
	output logic [31:0]                o_redirect_pc,
	output logic                       o_halted,
	output logic [LED_SLOTS*LED_W-1:0] o_led_commands
);

	opcode_e     opcode;
	alu_op_e     insn_op;
	alu_op_e     alu_op;
	logic [4:0]  rd;
	logic [26:0] target;
	logic [31:0] imm_ext;
	logic [31:0] pc_plus1;
	logic [31:0] branch_pc;
	logic [31:0] jump_pc;
	logic [31:0] alu_a;
	logic [31:0] alu_b;
	logic [31:0] alu_result;
	logic        not_equal;
	logic        less_than;
	logic        overflow;
	logic        use_imm;
	logic        rd_as_rt;
	logic        is_bex;
	logic        exc;
	logic        taken;
	logic        fire;
	logic        halted_q;
	logic [3:0]  led_slot;
	logic [LED_SLOTS*LED_W-1:0] led_q;

	assign opcode    = opcode_e'(i_insn[OPC_HI:OPC_LO]);
	assign insn_op   = alu_op_e'(i_insn[ALUOP_HI -: 5]);
	assign rd        = i_insn[RD_HI -: 5];
	assign target    = i_insn[RD_HI:0];
	assign imm_ext   = {{(32-IMM_W){i_insn[IMM_W-1]}}, i_insn[IMM_W-1:0]};
	assign pc_plus1  = i_insn_pc + 32'd1;
	assign branch_pc = pc_plus1 + imm_ext;
	assign jump_pc   = {i_insn_pc[31:27], target};

	assign use_imm  = (opcode == OP_ADDI) || (opcode == OP_LW) || (opcode == OP_SW);
	assign rd_as_rt = (opcode == OP_BNE) || (opcode == OP_BLT) || (opcode == OP_SW) ||
		(opcode == OP_JR);
	assign is_bex   = (opcode == OP_BEX);

	assign o_rs_addr = i_insn[RS_HI -: 5];
	assign o_rt_addr = rd_as_rt ? rd : is_bex ? REG_STATUS : i_insn[RT_HI -: 5];

	assign alu_a = is_bex ? i_rt_data : i_rs_data; // bex tests r30 against zero
	assign alu_b = use_imm ? imm_ext : is_bex ? 32'd0 : i_rt_data;

	always_comb begin
		case (opcode)
			OP_RTYPE:               alu_op = insn_op;
			OP_BNE, OP_BLT, OP_BEX: alu_op = ALU_SUB;
			default:                alu_op = ALU_ADD;
		endcase
	end

	alu u_alu (
		.i_a(alu_a),
		.i_b(alu_b),
		.i_op(alu_op),
		.i_shamt(i_insn[SHAMT_HI -: 5]),
		.o_result(alu_result),
		.o_not_equal(not_equal),
		.o_less_than(less_than),
		.o_overflow(overflow)
	);

	always_comb begin
		case (opcode)
			OP_BNE, OP_BEX:      taken = not_equal;
			OP_BLT:              taken = not_equal && !less_than; // rd < rs
			OP_J, OP_JAL, OP_JR: taken = 1'b1;
			default:             taken = 1'b0;
		endcase
	end

	assign o_redirect_pc = (opcode == OP_JR) ? i_rt_data :
		((opcode == OP_BNE) || (opcode == OP_BLT)) ? branch_pc : jump_pc;

	assign exc = overflow && ((opcode == OP_RTYPE) || (opcode == OP_ADDI));

	always_comb begin
		o_wb_rd     = rd;
		o_wb_result = alu_result;
		if (exc) begin
			o_wb_rd     = REG_STATUS;
			o_wb_result = (opcode == OP_ADDI) ? EXC_ADDI : (insn_op == ALU_SUB) ? EXC_SUB : EXC_ADD;
		end else if (opcode == OP_JAL) begin
			o_wb_rd     = REG_LINK;
			o_wb_result = pc_plus1;
		end else if (opcode == OP_SETX) begin
			o_wb_rd     = REG_STATUS;
			o_wb_result = {5'd0, target};
		end
	end

	assign o_wb_kind  = opcode;
	assign o_wb_store = i_rt_data;
	assign o_x_ready  = i_wb_ready && !halted_q;
	assign o_wb_valid = i_insn_valid && !halted_q;
	assign fire       = i_insn_valid && o_x_ready;
	assign o_redirect = fire && taken;
	assign led_slot   = i_rt_data[3:0];

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			halted_q <= 1'b0;
			led_q    <= '0;
		end else if (fire) begin
			if (opcode == OP_HALT)
				halted_q <= 1'b1;
			if ((opcode == OP_LED) && (led_slot < LED_SLOTS))
				led_q[led_slot*LED_W +: LED_W] <= i_rs_data[LED_W-1:0];
		end
	end

	assign o_halted       = halted_q;
	assign o_led_commands = led_q;

endmodule

// ==== verilog/stage_fetch.sv ====
`timescale 1ns/100ps

module stage_fetch import mem_pkg::*; (
	input  logic              clock,
	input  logic              i_rst_n,
	input  logic              i_run,
	output logic              o_req_valid,
	input  logic              i_req_ready,
	output logic [ADDR_W-1:0] o_req_addr,
	input  logic              i_resp_valid,
	input  logic [31:0]       i_resp_data,
	output logic              o_insn_valid,
	input  logic              i_x_ready,
	output logic [31:0]       o_insn,
	output logic [31:0]       o_insn_pc,
	input  logic              i_redirect,
	input  logic [31:0]       i_redirect_pc
);

	logic [31:0] pc_q;
	logic        pend_q;
	logic        discard_q;
	logic        buf_valid_q;
	logic [31:0] buf_insn_q;
	logic [31:0] buf_pc_q;
	logic        take;
	logic        req_fire;
	logic        resp_keep;

	assign take      = buf_valid_q && i_x_ready;
	// buffer is free by the time the response lands
	assign o_req_valid = i_run && !pend_q && !i_redirect && (!buf_valid_q || take);
	assign o_req_addr  = pc_q[ADDR_W-1:0];
	assign req_fire    = o_req_valid && i_req_ready;
	assign resp_keep   = i_resp_valid && !discard_q && !i_redirect;

	always_ff @(posedge clock) begin
		if (!i_rst_n) begin
			pc_q        <= 32'd0;
			pend_q      <= 1'b0;
			discard_q   <= 1'b0;
			buf_valid_q <= 1'b0;
		end else begin
			if (i_redirect)
				pc_q <= i_redirect_pc;
			else if (req_fire)
				pc_q <= pc_q + 32'd1;
			if (req_fire)
				pend_q <= 1'b1;
			else if (i_resp_valid)
				pend_q <= 1'b0;
			if (i_redirect && pend_q && !i_resp_valid)
				discard_q <= 1'b1; // stale word still on its way
			else if (i_resp_valid)
				discard_q <= 1'b0;
			if (resp_keep)
				buf_valid_q <= 1'b1;
			else if (take || i_redirect)
				buf_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (resp_keep) begin
			buf_insn_q <= i_resp_data;
			buf_pc_q   <= pc_q - 32'd1; // pc already stepped past it
		end
	end

	assign o_insn_valid = buf_valid_q;
	assign o_insn       = buf_insn_q;
	assign o_insn_pc    = buf_pc_q;

	assert property (@(posedge clock) disable iff (!i_rst_n)
		o_insn_valid && !i_x_ready |=> o_insn_valid && $stable(o_insn));

endmodule

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/100ps

module mem_arbiter import mem_pkg::*; (
	input  logic              clock,
	input  logic              i_rst_n,
	input  logic              i_dbg_valid,
	output logic              o_dbg_ready,
	input  logic              i_dbg_we,
	input  logic [ADDR_W-1:0] i_dbg_addr,
	input  logic [31:0]       i_dbg_wdata,
	input  logic              i_data_valid,
	output logic              o_data_ready,
	input  logic              i_data_we,
	input  logic [ADDR_W-1:0] i_data_addr,
	input  logic [31:0]       i_data_wdata,
	input  logic              i_fetch_valid,
	output logic              o_fetch_ready,
	input  logic              i_fetch_we,
	input  logic [ADDR_W-1:0] i_fetch_addr,
	input  logic [31:0]       i_fetch_wdata,
	output logic              o_mem_en,
	output logic              o_mem_we,
	output logic [ADDR_W-1:0] o_mem_addr,
	output logic [31:0]       o_mem_wdata,
	input  logic [31:0]       i_mem_rdata,
	output logic              o_dbg_rvalid,
	output logic              o_data_rvalid,
	output logic              o_fetch_rvalid,
	output logic [31:0]       o_rdata
);

	owner_e owner_q;
	logic   busy;

	assign busy          = (owner_q != OWN_NONE); // read response in flight
	assign o_dbg_ready   = !busy && i_dbg_valid;
	assign o_data_ready  = !busy && !i_dbg_valid && i_data_valid;
	assign o_fetch_ready = !busy && !i_dbg_valid && !i_data_valid && i_fetch_valid;
	assign o_mem_en      = o_dbg_ready || o_data_ready || o_fetch_ready;

	always_comb begin
		if (i_dbg_valid) begin
			o_mem_we    = i_dbg_we;
			o_mem_addr  = i_dbg_addr;
			o_mem_wdata = i_dbg_wdata;
		end else if (i_data_valid) begin
			o_mem_we    = i_data_we;
			o_mem_addr  = i_data_addr;
			o_mem_wdata = i_data_wdata;
		end else begin
			o_mem_we    = i_fetch_we;
			o_mem_addr  = i_fetch_addr;
			o_mem_wdata = i_fetch_wdata;
		end
	end

	always_ff @(posedge clock) begin
		if (!i_rst_n)
			owner_q <= OWN_NONE;
		else if (o_mem_en && !o_mem_we)
			owner_q <= o_dbg_ready ? OWN_DBG : o_data_ready ? OWN_DATA : OWN_FETCH;
		else
			owner_q <= OWN_NONE;
	end

	assign o_dbg_rvalid   = (owner_q == OWN_DBG);
	assign o_data_rvalid  = (owner_q == OWN_DATA);
	assign o_fetch_rvalid = (owner_q == OWN_FETCH);
	assign o_rdata        = i_mem_rdata;

	// a waiting data request keeps its valid and address
	assert property (@(posedge clock) disable iff (!i_rst_n)
		i_data_valid && !o_data_ready |=> i_data_valid && $stable(i_data_addr));

endmodule

// ==== verilog/unified_mem.sv ====
`timescale 1ns/100ps

module unified_mem import mem_pkg::*; (
	input  logic              clock,
	input  logic              i_en,
	input  logic              i_we,
	input  logic [ADDR_W-1:0] i_addr,
	input  logic [31:0]       i_wdata,
	output logic [31:0]       o_rdata
);

	logic [31:0] mem [MEM_WORDS];

	always_ff @(posedge clock) begin
		if (i_en) begin
			if (i_we)
				mem[i_addr] <= i_wdata;
			else
				o_rdata <= mem[i_addr]; // one cycle read latency
		end
	end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/100ps

module alu import isa_pkg::*; (
	input  logic [31:0] i_a,
	input  logic [31:0] i_b,
	input  alu_op_e     i_op,
	input  logic [4:0]  i_shamt,
	output logic [31:0] o_result,
	output logic        o_not_equal,
	output logic        o_less_than,
	output logic        o_overflow
);

	logic [31:0] sum;
	logic [31:0] diff;
	logic        add_ovf;
	logic        sub_ovf;

	assign sum     = i_a + i_b;
	assign diff    = i_a - i_b;
	assign add_ovf = (i_a[31] == i_b[31]) && (sum[31] != i_a[31]);
	assign sub_ovf = (i_a[31] != i_b[31]) && (diff[31] != i_a[31]);

	always_comb begin
		case (i_op)
			ALU_ADD: o_result = sum;
			ALU_SUB: o_result = diff;
			ALU_AND: o_result = i_a & i_b;
			ALU_OR:  o_result = i_a | i_b;
			ALU_SLL: o_result = i_a << i_shamt;
			ALU_SRA: o_result = $signed(i_a) >>> i_shamt;
			default: o_result = 32'd0;
		endcase
	end

	assign o_not_equal = |diff;
	assign o_less_than = diff[31] ^ sub_ovf; // signed a < b
	assign o_overflow  = ((i_op == ALU_ADD) && add_ovf) || ((i_op == ALU_SUB) && sub_ovf);

endmodule

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

	localparam int ADDR_W    = 12;
	localparam int MEM_WORDS = 4096;

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_DBG,
		OWN_DATA,
		OWN_FETCH
	} owner_e;

endpackage

// ==== verilog/isa_pkg.sv ====
package isa_pkg;

	typedef enum logic [4:0] {
		OP_RTYPE = 5'b00000,
		OP_J     = 5'b00001,
		OP_BNE   = 5'b00010,
		OP_JAL   = 5'b00011,
		OP_JR    = 5'b00100,
		OP_ADDI  = 5'b00101,
		OP_BLT   = 5'b00110,
		OP_SW    = 5'b00111,
		OP_LW    = 5'b01000,
		OP_LED   = 5'b01011,
		OP_SETX  = 5'b10101,
		OP_BEX   = 5'b10110,
		OP_HALT  = 5'b11111
	} opcode_e;

	typedef enum logic [4:0] {
		ALU_ADD = 5'd0,
		ALU_SUB = 5'd1,
		ALU_AND = 5'd2,
		ALU_OR  = 5'd3,
		ALU_SLL = 5'd4,
		ALU_SRA = 5'd5
	} alu_op_e;

	localparam int OPC_HI   = 31;
	localparam int OPC_LO   = 27;
	localparam int RD_HI    = 26; // also top of the jump target
	localparam int RS_HI    = 21;
	localparam int RT_HI    = 16;
	localparam int SHAMT_HI = 11;
	localparam int ALUOP_HI = 6;
	localparam int IMM_W    = 17;

	localparam logic [4:0] REG_LINK   = 5'd31;
	localparam logic [4:0] REG_STATUS = 5'd30;

	localparam logic [31:0] EXC_ADD  = 32'd1;
	localparam logic [31:0] EXC_ADDI = 32'd2;
	localparam logic [31:0] EXC_SUB  = 32'd3;

	localparam int LED_SLOTS = 9;
	localparam int LED_W     = 16;

endpackage
